// File: sim.f
src/stick_cmd_pkg.sv
src/gesture_hold.sv
src/command_latch.sv
src/stick_command.sv
test/stick_command_asserts.sv
test/tb_stick_command.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_stick_command
FILELIST  ?= sim.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
SIM_ARGS  ?= +verilator+error+limit+100

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TOP)
	-./$(BUILD_DIR)/V$(TOP) $(SIM_ARGS) 2>&1 | tee $(LOG)
	@if grep -q "Something failed" $(LOG); then \
		echo "Simulation FAILED, see $(LOG)"; exit 1; \
	fi
	@if ! grep -q "Everything OK" $(LOG); then \
		echo "Simulation ended early, see $(LOG)"; exit 1; \
	fi
	@echo "Simulation passed"

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: test/tb_stick_command.sv
`timescale 1ns/1ps

module tb_stick_command;

  import stick_cmd_pkg::*;

  // Short hold keeps the run brief
  localparam int      HOLD_TICKS   = 8;
  localparam int      RESET_CYCLES = 16;
  localparam int      MAX_CYCLES   = 40 * HOLD_TICKS + RESET_CYCLES;
  localparam ch_val_t CH_LOW       = ch_low_default;
  localparam ch_val_t CH_HIGH      = ch_high_default;

  // Named stick gestures whose values double as model indices
  typedef enum int {
    g_neutral  = 0,
    g_low_in   = 1,
    g_low_out  = 2,
    g_high_in  = 3,
    g_high_out = 4
  } gesture_t;

  logic         tmr_10hz;
  logic         rst_n;
  radio_frame_t radio;
  cmd_status_t  status;

  // Gesture the stimulus is showing on the sticks
  gesture_t cur_g;

  int unsigned error_cnt;
  int unsigned other_cnt;
  int unsigned cycle_cnt;
  int unsigned pulse_cnt;
  int unsigned seed_val;

  // Reference model with one counter per gesture
  int m_cnt  [1:4];
  bit m_prev [1:4];
  bit m_armed;
  bit m_logging;
  bit m_pulse;
  bit m_off;

  stick_command #(
    .HOLD_TICKS (HOLD_TICKS),
    .CH_LOW     (CH_LOW),
    .CH_HIGH    (CH_HIGH)
  ) u_stick_command (
    .tmr_10hz (tmr_10hz),
    .rst_n    (rst_n),
    .radio    (radio),
    .status   (status)
  );

  // 10 ns tick clock
  initial begin
    tmr_10hz = 1'b0;
    forever #5 tmr_10hz = ~tmr_10hz;
  end

  // Channel near the bottom stop
  function automatic ch_val_t low_val();
    return ch_val_t'($urandom % int'(CH_LOW));
  endfunction

  // Channel near the top stop
  function automatic ch_val_t high_val();
    return ch_val_t'(int'(CH_HIGH) + 1 + int'($urandom % (1023 - int'(CH_HIGH))));
  endfunction

  // Well away from both margins
  function automatic ch_val_t mid_val();
    return ch_val_t'(256 + $urandom % 512);
  endfunction

  // Random frame shaped into one gesture
  function automatic radio_frame_t make_frame(input gesture_t g);
    radio_frame_t f;
    f.throttle = mid_val();
    f.roll     = mid_val();
    f.elevator = mid_val();
    f.yaw      = mid_val();
    // Left stick corner picks the row
    if (g == g_low_in || g == g_low_out) begin
      f.throttle = low_val();
      f.elevator = high_val();
    end
    if (g == g_high_in || g == g_high_out) begin
      f.throttle = high_val();
      f.elevator = low_val();
    end
    // Right stick picks the direction
    if (g == g_low_in || g == g_high_in) begin
      f.roll = low_val();
      f.yaw  = high_val();
    end
    if (g == g_low_out || g == g_high_out) begin
      f.roll = high_val();
      f.yaw  = low_val();
    end
    return f;
  endfunction

  // Latch acts on last tick's held levels before the counters move
  always @(posedge tmr_10hz or negedge rst_n) begin : ref_model
    bit rise [1:4];
    if (!rst_n) begin
      for (int g = 1; g <= 4; g++) begin
        m_cnt[g]  = 0;
        m_prev[g] = 1'b0;
      end
      m_armed   = 1'b0;
      m_logging = 1'b0;
      m_pulse   = 1'b0;
      m_off     = 1'b0;
    end else begin
      for (int g = 1; g <= 4; g++) begin
        rise[g] = (m_cnt[g] == HOLD_TICKS) && !m_prev[g];
      end
      m_pulse = 1'b0;
      if (!m_off) begin
        if (rise[g_high_in]) begin
          m_off     = 1'b1;
          m_armed   = 1'b0;
          m_logging = 1'b0;
        end else if (rise[g_high_out]) begin
          m_pulse   = 1'b1;
          m_armed   = 1'b0;
          m_logging = 1'b0;
        end else begin
          if (rise[g_low_in]) m_armed = !m_armed;
          if (rise[g_low_out]) m_logging = !m_logging;
        end
      end
      for (int g = 1; g <= 4; g++) begin
        m_prev[g] = (m_cnt[g] == HOLD_TICKS);
        if (int'(cur_g) != g) m_cnt[g] = 0;
        else if (m_cnt[g] < HOLD_TICKS) m_cnt[g] = m_cnt[g] + 1;
      end
    end
  end

  task automatic report_mismatch(input string name, input int got, input int want);
    $display("mismatch %s: got 0x%h expected 0x%h", name, got, want);
    error_cnt++;
  endtask

  // Status sampled mid-cycle away from the tick edge
  always @(negedge tmr_10hz) begin
    if (rst_n) begin
      assert (status.armed === m_armed)
        else report_mismatch("armed", int'(status.armed), int'(m_armed));
      assert (status.logging === m_logging)
        else report_mismatch("logging", int'(status.logging), int'(m_logging));
      assert (status.sys_reset === m_pulse)
        else report_mismatch("sys_reset", int'(status.sys_reset), int'(m_pulse));
      assert (status.power_down === m_off)
        else report_mismatch("power_down", int'(status.power_down), int'(m_off));
      if (status.sys_reset) pulse_cnt++;
    end
  end

  // One gesture frame per tick
  task automatic hold_gesture(input gesture_t g, input int ticks);
    repeat (ticks) begin
      @(negedge tmr_10hz);
      radio = make_frame(g);
      cur_g = g;
    end
  endtask

  // Full hold then release
  task automatic full_hold(input gesture_t g);
    hold_gesture(g, HOLD_TICKS + 2);
    hold_gesture(g_neutral, 3);
  endtask

  task automatic apply_reset();
    @(negedge tmr_10hz);
    rst_n = 1'b0;
    radio = make_frame(g_neutral);
    cur_g = g_neutral;
    repeat (RESET_CYCLES) @(negedge tmr_10hz);
    rst_n = 1'b1;
  endtask

  task automatic check_all_clear();
    assert (status == '0) else report_mismatch("status", int'(status), 0);
  endtask

  task automatic end_of_run();
    int unsigned assert_cnt;
    int unsigned total;
    assert_cnt = u_stick_command.u_latch.u_asserts.fail_cnt;
    total      = error_cnt + assert_cnt + other_cnt;
    $display("errors: %0d mismatches, %0d assertion failures, %0d other",
             error_cnt, assert_cnt, other_cnt);
    if (total == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  endtask

  // Watchdog
  initial begin : watchdog
    cycle_cnt = 0;
    while (cycle_cnt < MAX_CYCLES) begin
      @(posedge tmr_10hz);
      cycle_cnt++;
    end
    $display("Timeout: test did not finish within %0d cycles", MAX_CYCLES);
    other_cnt++;
    end_of_run();
  end

  initial begin : stimulus
    seed_val  = $urandom(11270);
    error_cnt = 0;
    other_cnt = 0;
    pulse_cnt = 0;
    rst_n     = 1'b0;
    radio     = make_frame(g_neutral);
    cur_g     = g_neutral;
    apply_reset();
    check_all_clear();

    // Arm and keep holding past saturation
    hold_gesture(g_low_in, HOLD_TICKS + 6);
    assert (status.armed) else report_mismatch("armed", int'(status.armed), 1);
    hold_gesture(g_neutral, 3);
    // Second hold disarms
    full_hold(g_low_in);

    // Broken one tick short twice in a row
    hold_gesture(g_low_in, HOLD_TICKS - 1);
    hold_gesture(g_neutral, 1);
    hold_gesture(g_low_in, HOLD_TICKS - 1);
    hold_gesture(g_neutral, 3);
    assert (!status.armed) else report_mismatch("armed", int'(status.armed), 0);

    // Logging toggles on its own
    full_hold(g_low_out);
    full_hold(g_low_in);
    full_hold(g_low_out);
    assert (status.armed && !status.logging)
      else report_mismatch("status", int'(status), 8);
    full_hold(g_low_out);

    // System reset gives a single pulse
    pulse_cnt = 0;
    hold_gesture(g_high_out, HOLD_TICKS + 4);
    hold_gesture(g_neutral, 3);
    assert (pulse_cnt == 1) else report_mismatch("sys_reset pulses", pulse_cnt, 1);

    // Power-down locks out the low row
    full_hold(g_low_in);
    full_hold(g_low_out);
    hold_gesture(g_high_in, HOLD_TICKS + 4);
    hold_gesture(g_neutral, 3);
    full_hold(g_low_in);
    full_hold(g_low_out);
    assert (status == 4'h1) else report_mismatch("status", int'(status), 1);
    apply_reset();
    check_all_clear();

    // Mid-stick noise only
    hold_gesture(g_neutral, 40);
    check_all_clear();
    end_of_run();
  end

endmodule

// File: test/stick_command_asserts.sv
`timescale 1ns/1ps

module stick_command_asserts (
  input logic                       tmr_10hz,
  input logic                       rst_n,
  input stick_cmd_pkg::row_held_t   low_held,
  input stick_cmd_pkg::row_held_t   high_held,
  input stick_cmd_pkg::cmd_status_t status
);

  // Failed assertions so far
  int unsigned fail_cnt = 0;

  // Reset pulse lasts one tick
  a_reset_single : assert property (@(posedge tmr_10hz) disable iff (!rst_n)
    status.sys_reset |=> !status.sys_reset)
    else begin
      $error("sys_reset stayed high for two ticks");
      fail_cnt++;
    end

  // Power-down is sticky until rst_n
  a_off_sticky : assert property (@(posedge tmr_10hz) disable iff (!rst_n)
    status.power_down |=> status.power_down)
    else begin
      $error("power_down fell without rst_n");
      fail_cnt++;
    end

  // Powered off forces both flags low
  a_off_quiet : assert property (@(posedge tmr_10hz) disable iff (!rst_n)
    status.power_down |-> (!status.armed && !status.logging))
    else begin
      $error("armed or logging high while powered off");
      fail_cnt++;
    end

  // Arm flips one tick after a low-inward edge, high row may only clear it
  a_arm_cause : assert property (@(posedge tmr_10hz) disable iff (!rst_n)
    (status.armed != $past(status.armed)) |->
      (($past(low_held.inward) && !$past(low_held.inward, 2)) ||
       (!status.armed && ($past(high_held.inward) || $past(high_held.outward)))))
    else begin
      $error("armed changed without a held gesture edge");
      fail_cnt++;
    end

endmodule

bind command_latch stick_command_asserts u_asserts (
  .tmr_10hz  (tmr_10hz),
  .rst_n     (rst_n),
  .low_held  (low_held),
  .high_held (high_held),
  .status    (status)
);

// File: src/stick_command.sv
`timescale 1ns/1ps

module stick_command #(
  parameter int                     HOLD_TICKS = stick_cmd_pkg::hold_ticks_default,
  parameter stick_cmd_pkg::ch_val_t CH_LOW     = stick_cmd_pkg::ch_low_default,
  parameter stick_cmd_pkg::ch_val_t CH_HIGH    = stick_cmd_pkg::ch_high_default
) (
  input  logic                       tmr_10hz,
  input  logic                       rst_n,
  input  stick_cmd_pkg::radio_frame_t radio,
  output stick_cmd_pkg::cmd_status_t  status
);

  import stick_cmd_pkg::*;

  // Held gestures of each row
  row_held_t low_held;
  row_held_t high_held;

  // Throttle low row, arm and log gestures
  gesture_hold #(
    .ROW_HIGH   (1'b0),
    .HOLD_TICKS (HOLD_TICKS),
    .CH_LOW     (CH_LOW),
    .CH_HIGH    (CH_HIGH)
  ) u_low_row (
    .tmr_10hz (tmr_10hz),
    .rst_n    (rst_n),
    .radio    (radio),
    .held     (low_held)
  );

  // Throttle high row, reset and power-down gestures
  gesture_hold #(
    .ROW_HIGH   (1'b1),
    .HOLD_TICKS (HOLD_TICKS),
    .CH_LOW     (CH_LOW),
    .CH_HIGH    (CH_HIGH)
  ) u_high_row (
    .tmr_10hz (tmr_10hz),
    .rst_n    (rst_n),
    .radio    (radio),
    .held     (high_held)
  );

  // Edge detect and command flags
  command_latch u_latch (
    .tmr_10hz  (tmr_10hz),
    .rst_n     (rst_n),
    .low_held  (low_held),
    .high_held (high_held),
    .status    (status)
  );

endmodule

// File: src/command_latch.sv
`timescale 1ns/1ps

module command_latch (
  input  logic                      tmr_10hz,
  input  logic                      rst_n,
  input  stick_cmd_pkg::row_held_t   low_held,
  input  stick_cmd_pkg::row_held_t   high_held,
  output stick_cmd_pkg::cmd_status_t status
);

  import stick_cmd_pkg::*;

  // Arming FSM
  arm_state_t state_q;
  arm_state_t state_d;

  // Held levels from the previous tick
  row_held_t low_prev_q;
  row_held_t high_prev_q;

  // Rising edges of the held levels
  row_held_t low_rise;
  row_held_t high_rise;

  // Data log enable
  logic logging_q;
  logic logging_d;

  // Reset pulse register
  logic sys_reset_q;
  logic sys_reset_d;

  // A held level fires once, on the tick it first appears
  assign low_rise.inward   = low_held.inward   & ~low_prev_q.inward;
  assign low_rise.outward  = low_held.outward  & ~low_prev_q.outward;
  assign high_rise.inward  = high_held.inward  & ~high_prev_q.inward;
  assign high_rise.outward = high_held.outward & ~high_prev_q.outward;

  // Next state and flags
  always_comb begin
    state_d     = state_q;
    logging_d   = logging_q;
    // Pulse unless a reset gesture fires below
    sys_reset_d = 1'b0;

    // Powered off ignores every gesture until rst_n
    if (state_q != st_powered_off) begin
      if (high_rise.inward) begin
        // Power-down wins over everything
        state_d   = st_powered_off;
        logging_d = 1'b0;
      end else if (high_rise.outward) begin
        // System reset, drop arming and logging with it
        state_d     = st_disarmed;
        logging_d   = 1'b0;
        sys_reset_d = 1'b1;
      end else begin
        // Low row toggles
        if (low_rise.inward) begin
          case (state_q)
            st_disarmed: state_d = st_armed;
            st_armed:    state_d = st_disarmed;
            // Unused code falls back to safe
            default:     state_d = st_disarmed;
          endcase
        end
        if (low_rise.outward) begin
          logging_d = ~logging_q;
        end
      end
    end
  end

  // Registers
  always_ff @(posedge tmr_10hz or negedge rst_n) begin
    if (!rst_n) begin
      state_q     <= st_disarmed;
      logging_q   <= 1'b0;
      sys_reset_q <= 1'b0;
      low_prev_q  <= '0;
      high_prev_q <= '0;
    end else begin
      state_q     <= state_d;
      logging_q   <= logging_d;
      sys_reset_q <= sys_reset_d;
      // Edge history keeps tracking even while powered off
      low_prev_q  <= low_held;
      high_prev_q <= high_held;
    end
  end

  // Armed and power_down come straight from the FSM state
  assign status = '{
    armed:      (state_q == st_armed),
    logging:    logging_q,
    sys_reset:  sys_reset_q,
    power_down: (state_q == st_powered_off)
  };

endmodule

// File: src/gesture_hold.sv
`timescale 1ns/1ps

module gesture_hold #(
  parameter bit                     ROW_HIGH   = 1'b0,
  parameter int                     HOLD_TICKS = stick_cmd_pkg::hold_ticks_default,
  parameter stick_cmd_pkg::ch_val_t CH_LOW     = stick_cmd_pkg::ch_low_default,
  parameter stick_cmd_pkg::ch_val_t CH_HIGH    = stick_cmd_pkg::ch_high_default
) (
  input  logic                       tmr_10hz,
  input  logic                       rst_n,
  input  stick_cmd_pkg::radio_frame_t radio,
  output stick_cmd_pkg::row_held_t    held
);

  import stick_cmd_pkg::*;

  // Counter just wide enough to reach the hold length
  localparam int CNT_W = $clog2(HOLD_TICKS + 1);

  typedef logic [CNT_W-1:0] hold_cnt_t;

  // Saturation value
  localparam hold_cnt_t CNT_MAX = hold_cnt_t'(HOLD_TICKS);

  // Left stick sits in this row's corner
  logic corner;
  // Right stick direction
  logic stick_in;
  logic stick_out;
  // Gestures seen on this tick
  row_held_t present;

  // One run-length counter per gesture
  hold_cnt_t in_cnt_q;
  hold_cnt_t out_cnt_q;

  // Clear on absence, count up on presence, stop at the hold length
  function automatic hold_cnt_t next_count(input logic seen, input hold_cnt_t cnt);
    hold_cnt_t nxt;
    if (!seen) begin
      nxt = '0;
    end else if (cnt == CNT_MAX) begin
      nxt = cnt;
    end else begin
      nxt = cnt + 1'b1;
    end
    return nxt;
  endfunction

  // Left stick corner depends on the row
  generate
    if (ROW_HIGH) begin : g_top_row
      // Throttle up, elevator pulled fully back
      assign corner = (radio.throttle > CH_HIGH) && (radio.elevator < CH_LOW);
    end else begin : g_bottom_row
      // Throttle down, elevator pushed fully forward
      assign corner = (radio.throttle < CH_LOW) && (radio.elevator > CH_HIGH);
    end
  endgenerate

  // Roll left and yaw right
  assign stick_in  = (radio.roll < CH_LOW) && (radio.yaw > CH_HIGH);
  // Roll right and yaw left
  assign stick_out = (radio.roll > CH_HIGH) && (radio.yaw < CH_LOW);

  // Both sticks must agree on the same tick
  assign present.inward  = corner && stick_in;
  assign present.outward = corner && stick_out;

  // Counters, cleared by reset
  always_ff @(posedge tmr_10hz or negedge rst_n) begin
    if (!rst_n) begin
      in_cnt_q  <= '0;
      out_cnt_q <= '0;
    end else begin
      in_cnt_q  <= next_count(present.inward, in_cnt_q);
      out_cnt_q <= next_count(present.outward, out_cnt_q);
    end
  end

  // Held only while the counter is parked at saturation
  assign held.inward  = (in_cnt_q == CNT_MAX);
  assign held.outward = (out_cnt_q == CNT_MAX);

endmodule

// File: src/stick_cmd_pkg.sv
package stick_cmd_pkg;

  // One receiver channel, 0 to 1023
  typedef logic [9:0] ch_val_t;

  // Full receiver word, throttle in the top ten bits
  typedef struct packed {
    ch_val_t throttle;
    ch_val_t roll;
    ch_val_t elevator;
    ch_val_t yaw;
  } radio_frame_t;

  // Held levels of the two gestures of one stick row
  typedef struct packed {
    // Right stick pointing toward the centre
    logic inward;
    // Right stick pointing away from the centre
    logic outward;
  } row_held_t;

  // Flags handed to the flight controller
  typedef struct packed {
    logic armed;
    logic logging;
    // One tick wide
    logic sys_reset;
    // Sticky until rst_n
    logic power_down;
  } cmd_status_t;

  // Arming FSM of the command latch
  typedef enum logic [1:0] {
    st_disarmed,
    st_armed,
    st_powered_off
  } arm_state_t;

  // Stick edge margins, a few counts in from full travel
  localparam ch_val_t ch_low_default  = 10'd12;
  localparam ch_val_t ch_high_default = 10'd1012;

  // Roughly 3.1 s of hold at 10 Hz
  localparam int hold_ticks_default = 31;

endpackage
